// ==== src/ising_pkg.sv ====
/* Sizes are fixed for an 8-spin core; a J row must fit in one 32-bit word.
   Couplings and biases are two's complement, a spin bit of 1 stands for +1. */
`default_nettype none

package ising_pkg;

    ////////////////////////////////////////
    // Core dimensions
    ////////////////////////////////////////
    localparam int NUM_SPIN   = 8;
    localparam int BIT_J      = 4;
    localparam int BIT_H      = 4;
    localparam int SPIN_IDX_W = $clog2(NUM_SPIN);
    localparam int SWEEP_W    = 4;
    localparam int J_ROW_W    = NUM_SPIN * BIT_J;

    // Holds NUM_SPIN-1 products of a coupling and a spin plus the bias
    localparam int FIELD_W    = BIT_J + SPIN_IDX_W + 1;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////
    typedef logic [NUM_SPIN-1:0]              spin_vec_t;
    typedef logic [SPIN_IDX_W-1:0]            spin_idx_t;
    typedef logic [SWEEP_W-1:0]               sweep_t;
    typedef logic [NUM_SPIN-1:0][BIT_H-1:0]   h_vec_t;
    typedef logic signed [FIELD_W-1:0]        field_t;

    // One J row: raw word from the host, coupling array for the engine
    typedef union packed {
        logic [J_ROW_W-1:0]                 raw;
        logic [NUM_SPIN-1:0][BIT_J-1:0]     coef;
    } j_row_u;

endpackage

`default_nettype wire

// ==== src/ising_j_rd_if.sv ====
/* Read path of the J memory; raddr must hold from the ren cycle to the rvalid
   cycle, and rvalid always follows ren by exactly one cycle. */
`timescale 1ns/1ps
`default_nettype none

interface ising_j_rd_if;

    import ising_pkg::*;

    logic       ren;
    spin_idx_t  raddr;
    j_row_u     rdata;
    logic       rvalid;

    // Controller side
    modport requester (
        output ren,
        input  rvalid
    );

    modport memory (
        input  ren,
        input  raddr,
        output rdata,
        output rvalid
    );

    // Spin update only looks at the returned row
    modport consumer (
        input  raddr,
        input  rdata,
        input  rvalid
    );

endinterface

`default_nettype wire

// ==== src/ising_ctrl_fsm.sv ====
/* Start is taken only in IDLE; done_o is registered and rises as busy_o falls.
   The memory must answer every ren, there is no timeout in WAIT. */
`timescale 1ns/1ps
`default_nettype none

module ising_ctrl_fsm (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               start_i,
    input  logic               last_spin_i,
    input  logic               sweeps_left_zero_i,
    ising_j_rd_if.requester    rd,
    output logic               load_o,
    output logic               step_o,
    output logic               busy_o,
    output logic               done_o
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WAIT,
        FINISH
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   done_q;

    always_comb begin
        state_d = state_q;
        load_o  = 1'b0;
        step_o  = 1'b0;
        rd.ren  = 1'b0;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    load_o  = 1'b1;
                    // Zero sweeps skips the engine entirely
                    state_d = sweeps_left_zero_i ? FINISH : READ;
                end
            end
            READ: begin
                rd.ren  = 1'b1;
                state_d = WAIT;
            end
            WAIT: begin
                if (rd.rvalid) begin
                    step_o  = 1'b1;
                    state_d = (last_spin_i && sweeps_left_zero_i) ? FINISH : READ;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= (state_q == FINISH);
        end
    end

    assign busy_o = (state_q != IDLE);
    assign done_o = done_q;

endmodule

`default_nettype wire

// ==== src/ising_sweep_counter.sv ====
/* sweeps_left_zero_o looks at the count being written this cycle, so it is
   valid together with load_i and with the step that ends a sweep. */
`timescale 1ns/1ps
`default_nettype none

module ising_sweep_counter (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 load_i,
    input  logic                 step_i,
    input  ising_pkg::sweep_t    sweeps_i,
    output ising_pkg::spin_idx_t spin_idx_o,
    output logic                 last_spin_o,
    output logic                 sweeps_left_zero_o
);

    import ising_pkg::*;

    spin_idx_t idx_q;
    sweep_t    rem_q;
    sweep_t    rem_d;

    assign last_spin_o = (idx_q == spin_idx_t'(NUM_SPIN - 1));

    // Remaining sweeps after this edge
    always_comb begin
        rem_d = rem_q;
        if (load_i) begin
            rem_d = sweeps_i;
        end else if (step_i && last_spin_o) begin
            rem_d = rem_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            idx_q <= '0;
            rem_q <= '0;
        end else begin
            rem_q <= rem_d;
            if (load_i) begin
                idx_q <= '0;
            end else if (step_i) begin
                idx_q <= last_spin_o ? '0 : idx_q + 1'b1;
            end
        end
    end

    assign spin_idx_o         = idx_q;
    assign sweeps_left_zero_o = (rem_d == '0);

endmodule

`default_nettype wire

// ==== src/ising_j_mem.sv ====
/* Host writes are honoured only while the core is idle and engine reads only
   while busy; the rows themselves come up undefined after reset. */
`timescale 1ns/1ps
`default_nettype none

module ising_j_mem (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 busy_i,
    input  logic                 we_i,
    input  ising_pkg::spin_idx_t waddr_i,
    input  ising_pkg::j_row_u    wdata_i,
    ising_j_rd_if.memory         rd
);

    import ising_pkg::*;

    j_row_u mem_q [NUM_SPIN];
    logic   host_wr;
    logic   eng_rd;

    ////////////////////////////////////////
    // Request mux
    ////////////////////////////////////////
    assign host_wr = we_i & ~busy_i;
    assign eng_rd  = rd.ren & busy_i;

    always_ff @(posedge clk_i) begin
        if (host_wr) begin
            mem_q[waddr_i] <= wdata_i;
        end
        if (eng_rd) begin
            rd.rdata <= mem_q[rd.raddr];
        end
    end

    // One-cycle read latency
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd.rvalid <= 1'b0;
        end else begin
            rd.rvalid <= eng_rd;
        end
    end

endmodule

`default_nettype wire

// ==== src/ising_spin_update.sv ====
/* Zero-temperature rule, one spin per valid row; a zero field keeps the spin.
   The diagonal J[i][i] is skipped, biases are read only at load. */
`timescale 1ns/1ps
`default_nettype none

module ising_spin_update (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  load_i,
    input  ising_pkg::spin_vec_t  spin_init_i,
    input  ising_pkg::h_vec_t     h_bias_i,
    ising_j_rd_if.consumer        rd,
    output ising_pkg::spin_vec_t  spin_o
);

    import ising_pkg::*;

    spin_vec_t spin_q;
    h_vec_t    h_q;
    field_t    field;

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            h_q <= h_bias_i;
        end
    end

    ////////////////////////////////////////
    // Local field of spin raddr
    ////////////////////////////////////////
    always_comb begin
        field = field_t'($signed(h_q[rd.raddr]));
        for (int j = 0; j < NUM_SPIN; j++) begin
            field_t term;
            term = field_t'($signed(rd.rdata.coef[j]));
            if (j != int'(rd.raddr)) begin
                // Bit 1 adds J, bit 0 subtracts it
                field = spin_q[j] ? field + term : field - term;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            spin_q <= '0;
        end else if (load_i) begin
            spin_q <= spin_init_i;
        end else if (rd.rvalid) begin
            if (field > 0) begin
                spin_q[rd.raddr] <= 1'b1;
            end else if (field < 0) begin
                spin_q[rd.raddr] <= 1'b0;
            end
        end
    end

    assign spin_o = spin_q;

endmodule

`default_nettype wire

// ==== src/ising_core_top.sv ====
/* Inputs other than start_i are sampled only when a start is accepted; host J
   writes during a run are dropped without notice. */
`timescale 1ns/1ps
`default_nettype none

module ising_core_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 j_we_i,
    input  ising_pkg::spin_idx_t j_waddr_i,
    input  ising_pkg::j_row_u    j_wdata_i,
    input  ising_pkg::h_vec_t    h_bias_i,
    input  ising_pkg::spin_vec_t spin_init_i,
    input  ising_pkg::sweep_t    sweeps_i,
    input  logic                 start_i,
    output logic                 busy_o,
    output logic                 done_o,
    output ising_pkg::spin_vec_t spin_o
);

    import ising_pkg::*;

    logic      load;
    logic      step;
    logic      last_spin;
    logic      sweeps_left_zero;
    spin_idx_t spin_idx;

    ising_j_rd_if j_rd ();

    // Row address follows the spin being updated
    assign j_rd.raddr = spin_idx;

    ising_ctrl_fsm u_ctrl (
        .clk_i              (clk_i           ),
        .rst_n_i            (rst_n_i         ),
        .start_i            (start_i         ),
        .last_spin_i        (last_spin       ),
        .sweeps_left_zero_i (sweeps_left_zero),
        .rd                 (j_rd.requester  ),
        .load_o             (load            ),
        .step_o             (step            ),
        .busy_o             (busy_o          ),
        .done_o             (done_o          )
    );

    ising_sweep_counter u_counter (
        .clk_i              (clk_i           ),
        .rst_n_i            (rst_n_i         ),
        .load_i             (load            ),
        .step_i             (step            ),
        .sweeps_i           (sweeps_i        ),
        .spin_idx_o         (spin_idx        ),
        .last_spin_o        (last_spin       ),
        .sweeps_left_zero_o (sweeps_left_zero)
    );

    ising_j_mem u_j_mem (
        .clk_i   (clk_i      ),
        .rst_n_i (rst_n_i    ),
        .busy_i  (busy_o     ),
        .we_i    (j_we_i     ),
        .waddr_i (j_waddr_i  ),
        .wdata_i (j_wdata_i  ),
        .rd      (j_rd.memory)
    );

    ising_spin_update u_spin (
        .clk_i       (clk_i        ),
        .rst_n_i     (rst_n_i      ),
        .load_i      (load         ),
        .spin_init_i (spin_init_i  ),
        .h_bias_i    (h_bias_i     ),
        .rd          (j_rd.consumer),
        .spin_o      (spin_o       )
    );

endmodule

`default_nettype wire

// ==== verification/ising_core_tb.sv ====
/* Drives ising_core_top through reset, runs and ignored host traffic. Every J
   row is written before the first run because the memory has no reset. */
`timescale 1ns/1ps
`default_nettype none

module ising_core_tb;

    import ising_pkg::*;

    localparam int DONE_TIMEOUT = 600;

    logic        clk;
    logic        rst_n;
    logic        j_we;
    spin_idx_t   j_waddr;
    j_row_u      j_wdata;
    h_vec_t      h_bias;
    spin_vec_t   spin_init;
    sweep_t      sweeps;
    logic        start;
    logic        busy;
    logic        done;
    spin_vec_t   spin;

    logic [31:0] lfsr_q;
    logic [31:0] j_rows [NUM_SPIN];
    int          err_count;
    int          test_count;

    ising_core_top UUT (
        .clk_i       (clk      ),
        .rst_n_i     (rst_n    ),
        .j_we_i      (j_we     ),
        .j_waddr_i   (j_waddr  ),
        .j_wdata_i   (j_wdata  ),
        .h_bias_i    (h_bias   ),
        .spin_init_i (spin_init),
        .sweeps_i    (sweeps   ),
        .start_i     (start    ),
        .busy_o      (busy     ),
        .done_o      (done     ),
        .spin_o      (spin     )
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
    endtask

    task automatic write_row(input spin_idx_t addr, input logic [31:0] data);
        j_we        = 1'b1;
        j_waddr     = addr;
        j_wdata.raw = data;
        @(negedge clk);
        j_we        = 1'b0;
    endtask

    // New J rows, biases and initial spins
    task automatic load_random();
        logic [31:0] val;
        for (int i = 0; i < NUM_SPIN; i++) begin
            take_bits(32, val);
            j_rows[i] = val;
            write_row(spin_idx_t'(i), val);
        end
        take_bits(32, val);
        h_bias = val;
        take_bits(NUM_SPIN, val);
        spin_init = val[NUM_SPIN-1:0];
    endtask

    // Sequential zero-temperature sweeps, spin i = row i
    task automatic model_sweeps(input int n_sweeps, output spin_vec_t result);
        int field;
        int coef;
        result = spin_init;
        for (int s = 0; s < n_sweeps; s++) begin
            for (int i = 0; i < NUM_SPIN; i++) begin
                field = $signed(h_bias[i]);
                for (int j = 0; j < NUM_SPIN; j++) begin
                    coef = $signed(j_rows[i][4*j +: 4]);
                    if (j != i) begin
                        field = result[j] ? field + coef : field - coef;
                    end
                end
                if (field > 0) begin
                    result[i] = 1'b1;
                end else if (field < 0) begin
                    result[i] = 1'b0;
                end
            end
        end
    endtask

    // Start a run, optionally poke a J write or a start while busy
    task automatic run_core(input sweep_t n_sweeps, input logic poke_wr,
                            input logic poke_start, output int cycles);
        int waited;
        sweeps = n_sweeps;
        start  = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        waited = 0;
        while (!done && waited < DONE_TIMEOUT) begin
            j_we        = poke_wr && (waited == 2);
            start       = poke_start && (waited == 2);
            j_waddr     = spin_idx_t'(5);
            j_wdata.raw = ~j_rows[5];
            @(negedge clk);
            waited++;
        end
        j_we   = 1'b0;
        start  = 1'b0;
        cycles = waited;
        assert (done) else begin
            $display("Timed out waiting for done_o after %0d cycles", waited);
            err_count++;
        end
        assert (!busy) else begin
            $display("Fail busy_o with done_o: %h, expected 0", busy);
            err_count++;
        end
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    task automatic check_spins(input spin_vec_t exp_spin);
        assert (spin === exp_spin) else begin
            $display("Fail spin_o: %h, expected %h", spin, exp_spin);
            err_count++;
        end
    endtask

    task automatic check_cycles(input int cycles, input int n_sweeps);
        assert (cycles == 2 * NUM_SPIN * n_sweeps + 1) else begin
            $display("Fail done_o delay: %h cycles, expected %h", cycles,
                     2 * NUM_SPIN * n_sweeps + 1);
            err_count++;
        end
    endtask

    task automatic expect_quiet(input int n);
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
            assert (!done && !busy) else begin
                $display("Fail done_o/busy_o when idle: %h/%h, expected 0/0", done, busy);
                err_count++;
            end
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        spin_vec_t exp_spin;
        sweep_t    n;
        int        cycles;
        int        errs;

        rst_n      = 1'b0;
        j_we       = 1'b0;
        j_waddr    = '0;
        j_wdata    = '0;
        h_bias     = '0;
        spin_init  = '0;
        sweeps     = '0;
        start      = 1'b0;
        lfsr_q     = 32'ha22264d3;
        err_count  = 0;
        test_count = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        errs = err_count;
        @(negedge clk);
        assert (!busy && !done) else begin
            $display("Fail busy_o/done_o after reset: %h/%h, expected 0/0", busy, done);
            err_count++;
        end
        check_spins('0);
        end_test("reset state", errs);

        errs = err_count;
        load_random();
        run_core('0, 1'b0, 1'b0, cycles);
        check_spins(spin_init);
        check_cycles(cycles, 0);
        end_test("zero sweeps", errs);

        errs = err_count;
        load_random();
        model_sweeps(1, exp_spin);
        run_core(sweep_t'(1), 1'b0, 1'b0, cycles);
        check_spins(exp_spin);
        check_cycles(cycles, 1);
        end_test("single sweep", errs);

        errs = err_count;
        for (int k = 0; k < 4; k++) begin
            n = sweep_t'(4 * k + 3);
            load_random();
            model_sweeps(int'(n), exp_spin);
            run_core(n, 1'b0, 1'b0, cycles);
            check_spins(exp_spin);
            check_cycles(cycles, int'(n));
        end
        end_test("multi sweep", errs);

        // Write to row 5 while busy must not reach the memory
        errs = err_count;
        load_random();
        model_sweeps(2, exp_spin);
        run_core(sweep_t'(2), 1'b1, 1'b0, cycles);
        check_spins(exp_spin);
        run_core(sweep_t'(2), 1'b0, 1'b0, cycles);
        check_spins(exp_spin);
        check_cycles(cycles, 2);
        end_test("write while busy", errs);

        errs = err_count;
        load_random();
        model_sweeps(3, exp_spin);
        run_core(sweep_t'(3), 1'b0, 1'b1, cycles);
        check_spins(exp_spin);
        check_cycles(cycles, 3);
        expect_quiet(2 * NUM_SPIN * 3 + 4);
        check_spins(exp_spin);
        end_test("start while busy", errs);

        $display("%0d tests run, %0d errors", test_count, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
src/ising_pkg.sv
src/ising_j_rd_if.sv
src/ising_ctrl_fsm.sv
src/ising_sweep_counter.sv
src/ising_j_mem.sv
src/ising_spin_update.sv
src/ising_core_top.sv
verification/ising_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert -Wno-fatal --top-module ising_core_tb \
    -f files.f --Mdir "$OBJ" -o ising_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/ising_core_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    exit 1
fi
exit 0
